/* source/bus_pkg.sv */
package bus_pkg;

	// one master, one 32-bit data path end to end
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// one strobe bit per byte lane
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// axi response field, same on b and r channels
	localparam int RESP_WIDTH = 2;

	// bus address, one word
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// data word on axi and apb
	typedef logic [DATA_WIDTH-1:0] data_t;

	// byte-lane write strobe
	typedef logic [STRB_WIDTH-1:0] strb_t;

	// axi response code
	typedef logic [RESP_WIDTH-1:0] resp_t;

	// response codes the bridge can return
	// exokay and decerr never occur here
	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* source/soc_map_pkg.sv */
package soc_map_pkg;

	// slave windows, 4 KiB each
	localparam bus_pkg::addr_t LED_BASE  = 32'h1f00_0000;
	localparam bus_pkg::addr_t UART_BASE = 32'h1f00_1000;

	// address bits at and above this pick the slave
	// bits below it are the offset inside the window
	localparam int SLAVE_SEL_LSB = 12;

	// uart register offsets inside its window
	localparam bus_pkg::addr_t UART_DATA_OFS   = 32'h0000_0000;
	localparam bus_pkg::addr_t UART_STATUS_OFS = 32'h0000_0004;

	// led pins on the board
	localparam int LED_WIDTH = 4;

	// serial bit period in clk cycles
	localparam int CLKS_PER_BIT = 8;
	localparam int BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
	localparam logic [BAUD_CNT_WIDTH-1:0] BAUD_CNT_LAST = BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1);

	// start bit, eight data bits, stop bit
	localparam int FRAME_BITS = 10;
	localparam int BIT_CNT_WIDTH = $clog2(FRAME_BITS);
	localparam logic [BIT_CNT_WIDTH-1:0] BIT_CNT_LAST = BIT_CNT_WIDTH'(FRAME_BITS - 1);

endpackage

/* source/axi_apb_bridge.sv */
module axi_apb_bridge (
	input  logic           clk,
	input  logic           rst_n,

	input  bus_pkg::addr_t awaddr,
	input  logic           awvalid,
	output logic           awready,
	input  bus_pkg::data_t wdata,
	input  bus_pkg::strb_t wstrb,
	input  logic           wvalid,
	output logic           wready,
	output bus_pkg::resp_t bresp,
	output logic           bvalid,
	input  logic           bready,
	input  bus_pkg::addr_t araddr,
	input  logic           arvalid,
	output logic           arready,
	output bus_pkg::data_t rdata,
	output bus_pkg::resp_t rresp,
	output logic           rvalid,
	input  logic           rready,

	output logic           psel,
	output logic           penable,
	output logic           pwrite,
	output bus_pkg::addr_t paddr,
	output bus_pkg::data_t pwdata,
	output bus_pkg::strb_t pstrb,
	input  bus_pkg::data_t prdata,
	input  logic           pready,
	input  logic           pslverr
);

	// one transfer in flight, walked through the apb phases
	enum logic [1:0] {ST_IDLE, ST_SETUP, ST_ACCESS, ST_RESP} state_q, state_d;

	// direction of the transfer in flight
	logic           write_q;

	// captured request
	bus_pkg::addr_t paddr_q;
	bus_pkg::data_t pwdata_q;
	bus_pkg::strb_t pstrb_q;

	// captured apb answer, held until the master takes it
	bus_pkg::resp_t resp_q;
	bus_pkg::data_t rdata_q;

	logic           wr_take;
	logic           rd_take;
	logic           resp_taken;

	// write needs aw and w together, both accepted in one beat
	assign wr_take = (state_q == ST_IDLE) && awvalid && wvalid;

	// read loses to a write pair offered in the same cycle
	assign rd_take = (state_q == ST_IDLE) && arvalid && !(awvalid && wvalid);

	assign awready = wr_take;
	assign wready  = wr_take;
	assign arready = rd_take;

	// response leaves on the matching ready
	assign resp_taken = write_q ? bready : rready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (wr_take || rd_take) begin
					state_d = ST_SETUP;
				end
			end
			// setup lasts exactly one cycle
			ST_SETUP: begin
				state_d = ST_ACCESS;
			end
			// wait states until the slave is ready
			ST_ACCESS: begin
				if (pready) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				if (resp_taken) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
			write_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (wr_take) begin
				write_q <= 1'b1;
			end else if (rd_take) begin
				write_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		// latch request on accept
		if (wr_take) begin
			paddr_q  <= awaddr;
			pwdata_q <= wdata;
			pstrb_q  <= wstrb;
		end else if (rd_take) begin
			paddr_q  <= araddr;
			pwdata_q <= '0;
			// apb wants pstrb low on reads
			pstrb_q  <= '0;
		end
		// sample the slave on the completing access edge
		if ((state_q == ST_ACCESS) && pready) begin
			resp_q  <= pslverr ? bus_pkg::RESP_SLVERR : bus_pkg::RESP_OKAY;
			rdata_q <= prdata;
		end
	end

	// apb master side
	assign psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
	assign penable = (state_q == ST_ACCESS);
	assign pwrite  = write_q;
	assign paddr   = paddr_q;
	assign pwdata  = pwdata_q;
	assign pstrb   = pstrb_q;

	// axi response side, valid held until taken
	assign bvalid = (state_q == ST_RESP) && write_q;
	assign rvalid = (state_q == ST_RESP) && !write_q;
	assign bresp  = resp_q;
	assign rresp  = resp_q;
	assign rdata  = rdata_q;

endmodule

/* source/apb_mux.sv */
module apb_mux (
	input  logic           psel,
	input  bus_pkg::addr_t paddr,
	input  logic           penable,

	output logic           psel_led,
	output logic           psel_uart,

	input  bus_pkg::data_t prdata_led,
	input  logic           pready_led,
	input  logic           pslverr_led,
	input  bus_pkg::data_t prdata_uart,
	input  logic           pready_uart,
	input  logic           pslverr_uart,

	output bus_pkg::data_t prdata,
	output logic           pready,
	output logic           pslverr
);

	logic hit_led;
	logic hit_uart;

	// compare only the slave-select field, the offset passes through
	assign hit_led = paddr[bus_pkg::ADDR_WIDTH-1:soc_map_pkg::SLAVE_SEL_LSB]
		== soc_map_pkg::LED_BASE[bus_pkg::ADDR_WIDTH-1:soc_map_pkg::SLAVE_SEL_LSB];
	assign hit_uart = paddr[bus_pkg::ADDR_WIDTH-1:soc_map_pkg::SLAVE_SEL_LSB]
		== soc_map_pkg::UART_BASE[bus_pkg::ADDR_WIDTH-1:soc_map_pkg::SLAVE_SEL_LSB];

	// at most one select high
	assign psel_led  = psel && hit_led;
	assign psel_uart = psel && hit_uart;

	always_comb begin
		if (hit_led) begin
			prdata  = prdata_led;
			pready  = pready_led;
			pslverr = pslverr_led;
		end else if (hit_uart) begin
			prdata  = prdata_uart;
			pready  = pready_uart;
			pslverr = pslverr_uart;
		end else begin
			// unmapped hole, answer ourselves in the first access cycle
			prdata  = '0;
			pready  = psel && penable;
			pslverr = psel && penable;
		end
	end

endmodule

/* source/led_driver.sv */
module led_driver (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  bus_pkg::data_t                      pwdata,
	input  bus_pkg::strb_t                      pstrb,
	output bus_pkg::data_t                      prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic [soc_map_pkg::LED_WIDTH-1:0]   led
);

	logic [soc_map_pkg::LED_WIDTH-1:0] led_q;
	logic                              wr_en;

	// led bits live in byte lane 0, other lanes are ignored
	// no offset decode, the whole window maps to this register
	assign wr_en = psel && penable && pwrite && pstrb[0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			led_q <= '0;
		end else if (wr_en) begin
			led_q <= pwdata[soc_map_pkg::LED_WIDTH-1:0];
		end
	end

	assign led = led_q;

	// readback, upper bits zero
	assign prdata = {{(bus_pkg::DATA_WIDTH - soc_map_pkg::LED_WIDTH){1'b0}}, led_q};

	// zero wait states, never an error
	assign pready  = 1'b1;
	assign pslverr = 1'b0;

endmodule

/* source/uart_tx_apb.sv */
module uart_tx_apb (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           psel,
	input  logic           penable,
	input  logic           pwrite,
	input  bus_pkg::addr_t paddr,
	input  bus_pkg::data_t pwdata,
	output bus_pkg::data_t prdata,
	output logic           pready,
	output logic           pslverr,
	output logic           tx
);

	// offset inside the uart window
	logic [soc_map_pkg::SLAVE_SEL_LSB-1:0] ofs;
	logic                                  is_data;
	logic                                  is_status;
	logic                                  access;
	logic                                  data_wr;
	logic                                  start;

	// transmitter state
	logic                                  busy_q;
	logic [soc_map_pkg::BAUD_CNT_WIDTH-1:0] baud_q;
	logic [soc_map_pkg::BIT_CNT_WIDTH-1:0]  bit_q;
	// frame bits, lsb goes out first
	logic [soc_map_pkg::FRAME_BITS-1:0]     shift_q;

	assign ofs       = paddr[soc_map_pkg::SLAVE_SEL_LSB-1:0];
	assign is_data   = ofs == soc_map_pkg::UART_DATA_OFS[soc_map_pkg::SLAVE_SEL_LSB-1:0];
	assign is_status = ofs == soc_map_pkg::UART_STATUS_OFS[soc_map_pkg::SLAVE_SEL_LSB-1:0];

	// access phase of an apb transfer aimed at us
	assign access  = psel && penable;
	assign data_wr = access && pwrite && is_data;

	// a data write only starts a frame when idle
	assign start = data_wr && !busy_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q  <= 1'b0;
			baud_q  <= '0;
			bit_q   <= '0;
			// all ones keeps the line idle high
			shift_q <= '1;
		end else if (start) begin
			busy_q  <= 1'b1;
			baud_q  <= '0;
			bit_q   <= '0;
			// stop bit, data lsb first, start bit
			shift_q <= {1'b1, pwdata[7:0], 1'b0};
		end else if (busy_q) begin
			if (baud_q == soc_map_pkg::BAUD_CNT_LAST) begin
				baud_q  <= '0;
				// shift in ones so the line returns high
				shift_q <= {1'b1, shift_q[soc_map_pkg::FRAME_BITS-1:1]};
				if (bit_q == soc_map_pkg::BIT_CNT_LAST) begin
					// end of stop bit
					busy_q <= 1'b0;
				end else begin
					bit_q <= bit_q + 1'b1;
				end
			end else begin
				baud_q <= baud_q + 1'b1;
			end
		end
	end

	assign tx = shift_q[0];

	// status reads back busy in bit 0, everything else reads zero
	assign prdata = {{(bus_pkg::DATA_WIDTH - 1){1'b0}}, is_status && busy_q};

	// zero wait states
	assign pready = 1'b1;

	// data write while a frame is going out gets dropped
	assign pslverr = data_wr && busy_q;

endmodule

/* source/periph_top.sv */
module periph_top (
	input  logic                              clk,
	input  logic                              rst_n,

	input  bus_pkg::addr_t                    awaddr,
	input  logic                              awvalid,
	output logic                              awready,
	input  bus_pkg::data_t                    wdata,
	input  bus_pkg::strb_t                    wstrb,
	input  logic                              wvalid,
	output logic                              wready,
	output bus_pkg::resp_t                    bresp,
	output logic                              bvalid,
	input  logic                              bready,
	input  bus_pkg::addr_t                    araddr,
	input  logic                              arvalid,
	output logic                              arready,
	output bus_pkg::data_t                    rdata,
	output bus_pkg::resp_t                    rresp,
	output logic                              rvalid,
	input  logic                              rready,

	output logic [soc_map_pkg::LED_WIDTH-1:0] led,
	output logic                              tx
);

	// apb from bridge to decoder
	logic           psel;
	logic           penable;
	logic           pwrite;
	bus_pkg::addr_t paddr;
	bus_pkg::data_t pwdata;
	bus_pkg::strb_t pstrb;
	bus_pkg::data_t prdata;
	logic           pready;
	logic           pslverr;

	// per-slave selects and answers
	logic           psel_led;
	logic           psel_uart;
	bus_pkg::data_t prdata_led;
	logic           pready_led;
	logic           pslverr_led;
	bus_pkg::data_t prdata_uart;
	logic           pready_uart;
	logic           pslverr_uart;

	axi_apb_bridge u_bridge (
		.clk     (clk),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	apb_mux u_mux (
		.psel         (psel),
		.paddr        (paddr),
		.penable      (penable),
		.psel_led     (psel_led),
		.psel_uart    (psel_uart),
		.prdata_led   (prdata_led),
		.pready_led   (pready_led),
		.pslverr_led  (pslverr_led),
		.prdata_uart  (prdata_uart),
		.pready_uart  (pready_uart),
		.pslverr_uart (pslverr_uart),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	led_driver u_led (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel_led),
		.penable (penable),
		.pwrite  (pwrite),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata_led),
		.pready  (pready_led),
		.pslverr (pslverr_led),
		.led     (led)
	);

	// uart ignores pstrb, a data write always sends the low byte
	uart_tx_apb u_uart (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel_uart),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata_uart),
		.pready  (pready_uart),
		.pslverr (pslverr_uart),
		.tx      (tx)
	);

endmodule

/* tests/tb_periph_top.sv */
module tb_periph_top;

	logic           clk;
	logic           rst_n;
	bus_pkg::addr_t awaddr;
	logic           awvalid;
	logic           awready;
	bus_pkg::data_t wdata;
	bus_pkg::strb_t wstrb;
	logic           wvalid;
	logic           wready;
	bus_pkg::resp_t bresp;
	logic           bvalid;
	logic           bready;
	bus_pkg::addr_t araddr;
	logic           arvalid;
	logic           arready;
	bus_pkg::data_t rdata;
	bus_pkg::resp_t rresp;
	logic           rvalid;
	logic           rready;
	logic [soc_map_pkg::LED_WIDTH-1:0] led;
	logic           tx;

	// op, addr, wdata, strb, expected resp, expected rdata
	logic [107:0]   pat [0:63];
	int             npat;
	int             limit;
	logic [3:0]     op;
	bus_pkg::addr_t addr;
	bus_pkg::data_t wdat;
	bus_pkg::strb_t strb;
	bus_pkg::resp_t exp_resp;
	bus_pkg::data_t exp_data;
	bus_pkg::resp_t resp_first;
	bus_pkg::resp_t resp_held;
	bus_pkg::data_t data_first;
	bus_pkg::data_t data_held;
	logic [7:0]     frame_byte;
	logic           frame_done;
	string          name;

	periph_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_resp(input string test, input bus_pkg::resp_t exp,
			input bus_pkg::resp_t act);
		if (act !== exp) begin
			fail_now($sformatf("FAILED %s: expected %h, got %h", test, exp, act));
		end
	endtask

	task automatic check_data(input string test, input bus_pkg::data_t exp,
			input bus_pkg::data_t act);
		if (act !== exp) begin
			fail_now($sformatf("FAILED %s: expected %h, got %h", test, exp, act));
		end
	endtask

	task automatic check_byte(input string test, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			fail_now($sformatf("FAILED %s: expected %h, got %h", test, exp, act));
		end
	endtask

	// sample tx mid-bit, start bit found by its falling edge
	task automatic watch_frame(input logic [7:0] expected);
		logic [7:0] got;
		@(negedge tx);
		repeat (soc_map_pkg::CLKS_PER_BIT / 2) @(negedge clk);
		if (tx !== 1'b0) begin
			fail_now("start bit on tx was not low in its middle");
		end
		for (int b = 0; b < 8; b++) begin
			repeat (soc_map_pkg::CLKS_PER_BIT) @(negedge clk);
			got[b] = tx;
		end
		repeat (soc_map_pkg::CLKS_PER_BIT) @(negedge clk);
		if (tx !== 1'b1) begin
			fail_now("stop bit on tx was not high in its middle");
		end
		check_byte("uart frame", expected, got);
		frame_done = 1'b1;
	endtask

	// one axi-lite beat, ready on the response after a random delay
	task automatic run_transfer(input bit is_write, input bus_pkg::addr_t a,
			input bus_pkg::data_t d, input bus_pkg::strb_t s,
			output bus_pkg::resp_t r_first, output bus_pkg::resp_t r_held,
			output bus_pkg::data_t d_first, output bus_pkg::data_t d_held);
		int unsigned delay;
		delay = $urandom_range(5, 0);
		if (is_write) begin
			awaddr = a;
			wdata = d;
			wstrb = s;
			awvalid = 1'b1;
			wvalid = 1'b1;
			wait (awready && wready);
		end else begin
			araddr = a;
			arvalid = 1'b1;
			wait (arready);
		end
		// accepted on this edge
		@(posedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		arvalid = 1'b0;
		while (!(is_write ? bvalid : rvalid)) begin
			@(negedge clk);
		end
		r_first = is_write ? bresp : rresp;
		d_first = rdata;
		// back-pressure, response must hold
		repeat (delay) @(negedge clk);
		if (!(is_write ? bvalid : rvalid)) begin
			fail_now("response valid dropped before ready was given");
		end
		r_held = is_write ? bresp : rresp;
		d_held = rdata;
		bready = is_write;
		rready = !is_write;
		@(negedge clk);
		bready = 1'b0;
		rready = 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		frame_done = 1'b1;
		frame_byte = '0;
		void'($urandom(32'hf546_ce82));
		for (int k = 0; k < 64; k++) begin
			pat[k] = '0;
		end
		$readmemh("tests/periph_patterns.hex", pat);
		// op 0 ends the list
		npat = 0;
		while (npat < 64 && pat[npat][107:104] != 4'd0) begin
			npat++;
		end
		limit = (npat * (soc_map_pkg::FRAME_BITS * soc_map_pkg::CLKS_PER_BIT + 20) + 10) * 4;
		fork
			begin
				#(limit);
				fail_now("timeout, the tests did not finish in time");
			end
		join_none
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < npat; i++) begin
			op = pat[i][107:104];
			addr = pat[i][103:72];
			wdat = pat[i][71:40];
			strb = pat[i][39:36];
			exp_resp = pat[i][33:32];
			exp_data = pat[i][31:0];
			name = $sformatf("pattern %0d", i);
			// op 3 is a uart data write whose frame gets watched
			if (op == 4'd3) begin
				if (addr != soc_map_pkg::UART_BASE + soc_map_pkg::UART_DATA_OFS) begin
					fail_now("frame pattern does not address the uart data register");
				end
				frame_done = 1'b0;
				frame_byte = wdat[7:0];
				fork
					watch_frame(frame_byte);
				join_none
			end
			if (op == 4'd1 || op == 4'd2 || op == 4'd3) begin
				if (exp_resp != bus_pkg::RESP_OKAY && exp_resp != bus_pkg::RESP_SLVERR) begin
					fail_now("pattern file holds an unknown response code");
				end
				run_transfer(op != 4'd2, addr, wdat, strb, resp_first, resp_held,
					data_first, data_held);
				check_resp({name, " first resp"}, exp_resp, resp_first);
				check_resp({name, " held resp"}, exp_resp, resp_held);
				if (op == 4'd2) begin
					check_data({name, " first rdata"}, exp_data, data_first);
					check_data({name, " held rdata"}, exp_data, data_held);
				end
			end else if (op == 4'd4) begin
				// frame over, then one more bit time for busy to clear
				wait (frame_done);
				repeat (soc_map_pkg::CLKS_PER_BIT) @(negedge clk);
			end else if (op == 4'd5) begin
				check_data({name, " led pins"}, exp_data,
					{{(bus_pkg::DATA_WIDTH - soc_map_pkg::LED_WIDTH){1'b0}}, led});
			end else begin
				fail_now("pattern file holds an unknown operation code");
			end
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* tests/periph_patterns.hex */
// op(1=write 2=read 3=uart frame write 4=wait frame end 5=led pins 0=end)
// addr_wdata_strb_resp_rdata
1_1f000000_0000000a_1_0_00000000
5_00000000_00000000_0_0_0000000a
2_1f000000_00000000_0_0_0000000a
1_1f000008_00000005_e_0_00000000
5_00000000_00000000_0_0_0000000a
2_1f000004_00000000_0_0_0000000a
1_1f000000_000000f3_f_0_00000000
5_00000000_00000000_0_0_00000003
3_1f001000_000000a5_1_0_00000000
2_1f001004_00000000_0_0_00000001
1_1f001000_0000003c_1_2_00000000
2_1f001000_00000000_0_0_00000000
4_00000000_00000000_0_0_00000000
2_1f001004_00000000_0_0_00000000
1_1f002000_12345678_f_2_00000000
2_1f002000_00000000_0_2_00000000
3_1f001000_0000ff5a_1_0_00000000
4_00000000_00000000_0_0_00000000
1_1f001004_00000001_f_0_00000000
2_1f001004_00000000_0_0_00000000
0_00000000_00000000_0_0_00000000

/* tb.f */
source/bus_pkg.sv
source/soc_map_pkg.sv
source/axi_apb_bridge.sv
source/apb_mux.sv
source/led_driver.sv
source/uart_tx_apb.sv
source/periph_top.sv
tests/tb_periph_top.sv

/* Makefile */
TOP = tb_periph_top

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary -j 0 --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
